//--- sim/testdata_commands.txt
# kind(1 query 2 load 3 flag 4 unknown) nbytes cmd0..cmd4 divider rise fall arm rst
# nreply reply0..reply6, all hex, unused bytes 00
1 1 02 00 00 00 00 000000 00 00 0 0 4 31 41 4C 53 00 00 00
1 1 04 00 00 00 00 000000 00 00 0 0 7 01 4C 41 00 20 08 00
2 5 80 78 56 34 12 345678 00 00 0 0 0 00 00 00 00 00 00 00
2 5 C0 A5 FF 00 11 345678 A5 00 0 0 0 00 00 00 00 00 00 00
2 5 C1 3C 00 00 00 345678 A5 3C 0 0 0 00 00 00 00 00 00 00
3 1 01 00 00 00 00 345678 A5 3C 1 0 0 00 00 00 00 00 00 00
3 1 00 00 00 00 00 345678 A5 3C 0 1 0 00 00 00 00 00 00 00
3 1 01 00 00 00 00 345678 A5 3C 1 0 0 00 00 00 00 00 00 00
4 1 11 00 00 00 00 345678 A5 3C 1 0 0 00 00 00 00 00 00 00
1 1 02 00 00 00 00 345678 A5 3C 1 0 4 31 41 4C 53 00 00 00
2 5 80 EF CD AB 99 ABCDEF A5 3C 1 0 0 00 00 00 00 00 00 00
3 1 00 00 00 00 00 ABCDEF A5 3C 0 1 0 00 00 00 00 00 00 00

//--- files.f
+incdir+src
src/sump_pkg.sv
src/uart_rx.sv
src/command_decoder.sv
src/controller.sv
src/meta_sender.sv
src/uart_tx.sv
src/logic_analyzer_top.sv
sim/tb_logic_analyzer.sv

//--- sim/tb_logic_analyzer.sv
`timescale 1ns/1ps
`default_nettype none
`include "sump_macros.svh"

module tb_logic_analyzer;

    localparam int MAX_TESTS = 32;
    localparam int BIT_CYCLES = `CLKS_PER_BIT;

    logic               clock;
    logic               ext_reset;
    logic               rx;
    logic               tx;
    logic               analyzer_reset;
    logic               arm;
    sump_pkg::divider_t divider;
    sump_pkg::pattern_t rise_pattern;
    sump_pkg::pattern_t fall_pattern;

    // One row per data file line
    int                 t_kind   [MAX_TESTS];
    int                 t_nbytes [MAX_TESTS];
    logic [4:0][7:0]    t_cmd    [MAX_TESTS];   // Command bytes, byte 0 sent first
    sump_pkg::divider_t t_div    [MAX_TESTS];
    sump_pkg::pattern_t t_rise   [MAX_TESTS];
    sump_pkg::pattern_t t_fall   [MAX_TESTS];
    logic               t_arm    [MAX_TESTS];
    logic               t_rst    [MAX_TESTS];   // analyzer_reset pulse expected
    int                 t_nreply [MAX_TESTS];
    logic [6:0][7:0]    t_reply  [MAX_TESTS];

    int         num_tests;
    int         total_bytes;
    int         error_count;
    int         check_count;
    int         cycle_count;
    int         cycle_limit;
    int         reset_cycles;                   // analyzer_reset high cycles this test
    logic [7:0] reply_q[$];                     // Bytes seen on tx

    logic_analyzer_top dut (
        .clock          (clock),
        .ext_reset      (ext_reset),
        .rx             (rx),
        .tx             (tx),
        .analyzer_reset (analyzer_reset),
        .arm            (arm),
        .divider        (divider),
        .rise_pattern   (rise_pattern),
        .fall_pattern   (fall_pattern)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;              // 4 ns period
    end

    // Watchdog, limit set once the data file is read
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, DUT stopped answering", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (analyzer_reset === 1'b1) reset_cycles <= reset_cycles + 1;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] b);
        int i;
        rx = 1'b0;
        wait_cycles(BIT_CYCLES);
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            wait_cycles(BIT_CYCLES);
        end
        rx = 1'b1;
        wait_cycles(BIT_CYCLES);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_divider(input string name, input sump_pkg::divider_t got,
                                 input sump_pkg::divider_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_pattern(input string name, input sump_pkg::pattern_t got,
                                 input sump_pkg::pattern_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $realtime, name, got, exp);
            error_count++;
        end
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            1:       return "query";
            2:       return "load";
            3:       return "flag";
            4:       return "unknown opcode";
            default: return "other";
        endcase
    endfunction

    ////////////////////////////////////////
    // Data file
    ////////////////////////////////////////

    task automatic load_tests();
        int               fd;
        int               code;
        int               code_r;
        logic [31:0]      kind, nb, c0, c1, c2, c3, c4, dv, rs, fl, ar, rt, nr;
        logic [31:0]      r0, r1, r2, r3, r4, r5, r6;
        logic [8*128-1:0] skip_line;
        bit               done;
        fd = $fopen("sim/testdata_commands.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/testdata_commands.txt");
            error_count++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %h", kind);
                if (code == 1) begin
                    code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h",
                                   nb, c0, c1, c2, c3, c4, dv, rs, fl, ar, rt, nr);
                    code_r = $fscanf(fd, " %h %h %h %h %h %h %h", r0, r1, r2, r3, r4, r5, r6);
                    if (code != 12 || code_r != 7 || num_tests == MAX_TESTS) begin
                        $display("Malformed line %0d in data file", num_tests + 1);
                        error_count++;
                        done = 1'b1;
                    end else begin
                        t_kind[num_tests]   = kind;
                        t_nbytes[num_tests] = nb;
                        t_cmd[num_tests]    = {c4[7:0], c3[7:0], c2[7:0], c1[7:0], c0[7:0]};
                        t_div[num_tests]    = dv[23:0];
                        t_rise[num_tests]   = rs[`SAMPLE_WIDTH-1:0];
                        t_fall[num_tests]   = fl[`SAMPLE_WIDTH-1:0];
                        t_arm[num_tests]    = ar[0];
                        t_rst[num_tests]    = rt[0];
                        t_nreply[num_tests] = nr;
                        t_reply[num_tests]  = {r6[7:0], r5[7:0], r4[7:0], r3[7:0],
                                               r2[7:0], r1[7:0], r0[7:0]};
                        total_bytes += nb + nr;
                        num_tests++;
                    end
                end else if (code == 0) begin
                    if ($fgets(skip_line, fd) == 0) done = 1'b1;   // Comment line
                end else begin
                    done = 1'b1;                                    // End of file
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Tx monitor
    ////////////////////////////////////////

    initial begin : tx_monitor
        logic [7:0] b;
        int         i;
        forever begin
            @(negedge clock);
            if (ext_reset === 1'b0 && tx === 1'b0) begin
                wait_cycles(BIT_CYCLES / 2);            // Middle of start bit
                for (i = 0; i < 8; i++) begin
                    wait_cycles(BIT_CYCLES);
                    b[i] = tx;
                end
                wait_cycles(BIT_CYCLES);
                if (tx !== 1'b1) begin
                    $display("Framing error at %0t, tx stop bit was low", $realtime);
                    error_count++;
                end
                reply_q.push_back(b);
            end
        end
    end

    task automatic run_test(input int t);
        int errors_before;
        int k;
        errors_before = error_count;
        reply_q.delete();
        reset_cycles = 0;
        for (k = 0; k < t_nbytes[t]; k++) begin
            send_byte(t_cmd[t][k]);
        end
        while (reply_q.size() < t_nreply[t]) @(negedge clock);  // Watchdog bounds this
        wait_cycles(20 * BIT_CYCLES);
        check_divider("divider", divider, t_div[t]);
        check_pattern("rise_pattern", rise_pattern, t_rise[t]);
        check_pattern("fall_pattern", fall_pattern, t_fall[t]);
        check_flag("arm", arm, t_arm[t]);
        check_flag("analyzer_reset pulse", reset_cycles != 0, t_rst[t]);
        if (reset_cycles > 1) begin
            $display("analyzer_reset stayed high for %0d cycles", reset_cycles);
            error_count++;
        end
        if (reply_q.size() != t_nreply[t]) begin
            $display("Reply had %0d bytes, expected %0d", reply_q.size(), t_nreply[t]);
            error_count++;
        end else begin
            for (k = 0; k < t_nreply[t]; k++) begin
                check_byte($sformatf("tx byte %0d", k), reply_q[k], t_reply[t][k]);
            end
        end
        $display("Test %0d (%s): %s", t + 1, kind_name(t_kind[t]),
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : main
        int t;
        $timeformat(-9, 1, " ns", 10);
        rx          = 1'b1;                     // Idle line
        ext_reset   = 1'b1;
        num_tests   = 0;
        total_bytes = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_tests();
        if (num_tests == 0) begin
            $display("No tests found in data file");
            error_count++;
        end
        // 20 bit periods per byte each way, one more window per test
        cycle_limit = (total_bytes * 20 + num_tests * 20) * BIT_CYCLES + 500;
        repeat (2) @(posedge clock);
        @(negedge clock);
        ext_reset = 1'b0;
        wait_cycles(4);
        check_flag("tx", tx, 1'b1);
        check_flag("arm", arm, 1'b0);
        check_divider("divider", divider, '0);
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", num_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/logic_analyzer_top.sv
`timescale 1ns/1ps
`default_nettype none

module logic_analyzer_top (
    input  logic               clock,
    input  logic               ext_reset,
    input  logic               rx,
    output logic               tx,
    output logic               analyzer_reset,
    output logic               arm,
    output sump_pkg::divider_t divider,
    output sump_pkg::pattern_t rise_pattern,
    output sump_pkg::pattern_t fall_pattern
);

    logic [7:0]              rx_data;
    logic                    rx_valid;
    logic [7:0]              opcode;
    sump_pkg::command_word_u command;
    logic                    cmd_recv_rx;
    logic                    begin_meta_transmit;
    sump_pkg::reply_sel_e    reply_sel;
    logic                    meta_busy;
    logic [7:0]              tx_data;
    logic                    tx_start;
    logic                    transmit_busy;

    ////////////////////////////////////////
    // Command path
    ////////////////////////////////////////

    uart_rx u_uart_rx (
        .clock     (clock),
        .ext_reset (ext_reset),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    command_decoder u_command_decoder (
        .clock       (clock),
        .ext_reset   (ext_reset),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .opcode      (opcode),
        .command     (command),
        .cmd_recv_rx (cmd_recv_rx)
    );

    controller u_controller (
        .clock               (clock),
        .ext_reset           (ext_reset),
        .opcode              (opcode),
        .command             (command),
        .cmd_recv_rx         (cmd_recv_rx),
        .meta_busy           (meta_busy),
        .analyzer_reset      (analyzer_reset),
        .divider             (divider),
        .arm                 (arm),
        .begin_meta_transmit (begin_meta_transmit),
        .reply_sel           (reply_sel),
        .rise_pattern        (rise_pattern),
        .fall_pattern        (fall_pattern)
    );

    ////////////////////////////////////////
    // Reply path
    ////////////////////////////////////////

    meta_sender u_meta_sender (
        .clock               (clock),
        .ext_reset           (ext_reset),
        .begin_meta_transmit (begin_meta_transmit),
        .reply_sel           (reply_sel),
        .transmit_busy       (transmit_busy),
        .tx_data             (tx_data),
        .tx_start            (tx_start),
        .meta_busy           (meta_busy)
    );

    uart_tx u_uart_tx (
        .clock         (clock),
        .ext_reset     (ext_reset),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .tx            (tx),
        .transmit_busy (transmit_busy)
    );

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "sump_macros.svh"

module uart_tx (
    input  logic       clock,
    input  logic       ext_reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,       // Only while idle
    output logic       tx,             // Serial line, idles high
    output logic       transmit_busy
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bits_left;      // Bits still to drive after this one
    logic [8:0]       frame;          // Data bits then stop bit
    logic             bit_done;

    assign bit_done = transmit_busy && (clk_cnt == FULL_BIT);

    ////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            tx            <= 1'b1;
            transmit_busy <= 1'b0;
            clk_cnt       <= '0;
            bits_left     <= '0;
        end else if (!transmit_busy) begin
            clk_cnt <= '0;
            if (tx_start) begin
                tx            <= 1'b0;         // Start bit
                transmit_busy <= 1'b1;
                bits_left     <= 4'd9;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            if (bits_left == 4'd0) begin
                transmit_busy <= 1'b0;         // Stop bit finished
            end else begin
                tx        <= frame[0];
                bits_left <= bits_left - 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Shift register, LSB first
    always_ff @(posedge clock) begin
        if (!transmit_busy && tx_start) begin
            frame <= {1'b1, tx_data};
        end else if (bit_done) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

    a_start_when_idle : assert property (@(posedge clock) disable iff (ext_reset)
        tx_start |-> !transmit_busy)
        else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

//--- src/meta_sender.sv
`timescale 1ns/1ps
`default_nettype none
`include "sump_macros.svh"

module meta_sender (
    input  logic                 clock,
    input  logic                 ext_reset,
    input  logic                 begin_meta_transmit,
    input  sump_pkg::reply_sel_e reply_sel,      // Stable for the whole reply
    input  logic                 transmit_busy,
    output logic [7:0]           tx_data,
    output logic                 tx_start,
    output logic                 meta_busy
);

    logic [2:0] idx;          // Next byte to send
    logic [2:0] reply_len;
    logic       pending;      // Start issued, transmitter not busy yet
    logic       issue;

    // Byte tables
    function automatic logic [7:0] table_byte(input sump_pkg::reply_sel_e sel,
                                              input logic [2:0] i);
        logic [7:0] b;
        if (sel == sump_pkg::REPLY_ID) begin
            case (i)
                3'd0:    b = "1";
                3'd1:    b = "A";
                3'd2:    b = "L";
                default: b = "S";
            endcase
        end else begin
            case (i)
                3'd0:    b = 8'h01;                  // Device name key
                3'd1:    b = "L";
                3'd2:    b = "A";
                3'd3:    b = 8'h00;                  // Name terminator
                3'd4:    b = 8'h20;                  // Probe count key
                3'd5:    b = 8'(`SAMPLE_WIDTH);
                default: b = 8'h00;                  // End of record
            endcase
        end
        return b;
    endfunction

    assign reply_len = (reply_sel == sump_pkg::REPLY_ID) ? 3'd4 : 3'd7;
    assign issue     = meta_busy && !pending && !transmit_busy && (idx != reply_len);

    ////////////////////////////////////////
    // Reply sequencer
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            meta_busy <= 1'b0;
            tx_start  <= 1'b0;
            idx       <= '0;
            pending   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (!meta_busy) begin
                if (begin_meta_transmit) begin
                    meta_busy <= 1'b1;
                    idx       <= '0;
                    pending   <= 1'b0;
                end
            end else if (pending) begin
                pending <= !transmit_busy;       // Transmitter took the byte
            end else if (issue) begin
                tx_start <= 1'b1;
                pending  <= 1'b1;
                idx      <= idx + 3'd1;
            end else if (!transmit_busy) begin
                meta_busy <= 1'b0;               // Last stop bit is out
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            tx_data <= table_byte(reply_sel, idx);
        end
    end

endmodule

`default_nettype wire

//--- src/controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "sump_macros.svh"

module controller (
    input  logic                    clock,
    input  logic                    ext_reset,
    input  logic [7:0]              opcode,        // From command decoder
    input  sump_pkg::command_word_u command,
    input  logic                    cmd_recv_rx,   // Command complete
    input  logic                    meta_busy,     // Reply in flight
    output logic                    analyzer_reset,
    output sump_pkg::divider_t      divider,
    output logic                    arm,
    output logic                    begin_meta_transmit,
    output sump_pkg::reply_sel_e    reply_sel,
    output sump_pkg::pattern_t      rise_pattern,
    output sump_pkg::pattern_t      fall_pattern
);

    sump_pkg::controller_state_e state;

    ////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            state               <= sump_pkg::IDLE;
            analyzer_reset      <= 1'b0;
            arm                 <= 1'b0;
            divider             <= '0;
            rise_pattern        <= '0;
            fall_pattern        <= '0;
            begin_meta_transmit <= 1'b0;
            reply_sel           <= sump_pkg::REPLY_ID;
        end else begin
            analyzer_reset      <= 1'b0;   // Pulses only
            begin_meta_transmit <= 1'b0;

            case (state)
                // Wait for the decoder
                sump_pkg::IDLE: begin
                    if (cmd_recv_rx) begin
                        state <= sump_pkg::CMD_RECEIVED;
                    end
                end

                // Act on the held opcode
                sump_pkg::CMD_RECEIVED: begin
                    state <= sump_pkg::IDLE;
                    case (opcode)
                        `OP_RESET: begin
                            analyzer_reset <= 1'b1;
                            arm            <= 1'b0;    // Settings survive
                        end
                        `OP_ARM: begin
                            arm <= 1'b1;
                        end
                        `OP_QUERY_ID: begin
                            reply_sel           <= sump_pkg::REPLY_ID;
                            begin_meta_transmit <= 1'b1;
                            state               <= sump_pkg::META_WAIT;
                        end
                        `OP_QUERY_META: begin
                            reply_sel           <= sump_pkg::REPLY_META;
                            begin_meta_transmit <= 1'b1;
                            state               <= sump_pkg::META_WAIT;
                        end
                        `OP_SET_DIVIDER: begin
                            divider <= command.div.divider;     // Low 24 bits
                        end
                        `OP_SET_RISE: begin
                            rise_pattern <= command.pat.pattern;
                        end
                        `OP_SET_FALL: begin
                            fall_pattern <= command.pat.pattern;
                        end
                        default: begin
                            // Unknown opcode, back to IDLE untouched
                        end
                    endcase
                end

                // Meta sender raises busy one cycle after the start pulse,
                // so stay put while the pulse is still out
                sump_pkg::META_WAIT: begin
                    if (!meta_busy && !begin_meta_transmit) begin
                        state <= sump_pkg::IDLE;
                    end
                end

                default: state <= sump_pkg::IDLE;
            endcase
        end
    end

    // A new reply only starts once the last one has drained
    a_no_start_while_busy : assert property (@(posedge clock) disable iff (ext_reset)
        !(begin_meta_transmit && meta_busy))
        else $error("begin_meta_transmit while meta sender busy");

endmodule

`default_nettype wire

//--- src/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
    input  logic                    clock,
    input  logic                    ext_reset,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic [7:0]              opcode,      // Held until next command
    output sump_pkg::command_word_u command,
    output logic                    cmd_recv_rx  // One cycle per command
);

    logic [2:0]  byte_cnt;       // 0 waits for an opcode, 1..4 argument bytes
    logic [7:0]  long_opcode;    // Opcode parked while arguments arrive
    logic [23:0] arg_low;        // First three argument bytes

    ////////////////////////////////////////
    // Framing
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            byte_cnt    <= '0;
            cmd_recv_rx <= 1'b0;
        end else begin
            cmd_recv_rx <= 1'b0;
            if (rx_valid) begin
                if (byte_cnt == 3'd0) begin
                    if (rx_data[7]) begin
                        byte_cnt <= 3'd1;       // Long command
                    end else begin
                        cmd_recv_rx <= 1'b1;    // Short command done
                    end
                end else if (byte_cnt == 3'd4) begin
                    byte_cnt    <= '0;
                    cmd_recv_rx <= 1'b1;        // Fifth byte in
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

    // Opcode and argument capture
    always_ff @(posedge clock) begin
        if (rx_valid) begin
            if (byte_cnt == 3'd0) begin
                long_opcode <= rx_data;
                if (!rx_data[7]) begin
                    opcode  <= rx_data;
                    command <= '0;              // No argument
                end
            end else if (byte_cnt == 3'd4) begin
                opcode  <= long_opcode;
                command <= {rx_data, arg_low};  // LSB arrived first
            end else begin
                arg_low <= {rx_data, arg_low[23:8]};
            end
        end
    end

    // Commands are at least one byte time apart
    a_single_cmd_pulse : assert property (@(posedge clock) disable iff (ext_reset)
        cmd_recv_rx |=> !cmd_recv_rx)
        else $error("cmd_recv_rx high on back-to-back cycles");

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "sump_macros.svh"

module uart_rx (
    input  logic       clock,
    input  logic       ext_reset,
    input  logic       rx,            // Serial line, idles high
    output logic [7:0] rx_data,
    output logic       rx_valid       // One cycle per good byte
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    logic [1:0]       rx_sync;        // Two-flop synchronizer
    logic             rx_s;
    logic             active;         // Frame in progress
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;        // 0 start, 1..8 data, 9 stop
    logic [7:0]       shift;
    logic             sample;

    assign rx_s = rx_sync[1];

    // Half a bit on the start bit, so later samples land mid-bit
    assign sample = active && (clk_cnt == ((bit_idx == 4'd0) ? HALF_BIT : FULL_BIT));

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            rx_sync <= 2'b11;         // Line idle
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    ////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge ext_reset) begin
        if (ext_reset) begin
            active   <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                clk_cnt <= '0;
                bit_idx <= '0;
                active  <= !rx_s;     // Falling edge opens a frame
            end else if (sample) begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rx_s) begin
                    active <= 1'b0;   // Glitch, not a real start bit
                end else if (bit_idx == 4'd9) begin
                    active   <= 1'b0;
                    rx_valid <= rx_s; // Low stop bit drops the byte
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Data bits, LSB first
    always_ff @(posedge clock) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift <= {rx_s, shift[7:1]};
        end
        if (sample && bit_idx == 4'd9) begin
            rx_data <= shift;         // Lines up with rx_valid
        end
    end

endmodule

`default_nettype wire

//--- src/sump_pkg.sv
`default_nettype none

package sump_pkg;

    `include "sump_macros.svh"

    // Sample clock divider, 24 bits as in SUMP
    typedef logic [23:0] divider_t;

    // One bit per probe channel
    typedef logic [`SAMPLE_WIDTH-1:0] pattern_t;

    // Divider load view
    typedef struct packed {
        logic [7:0] unused;        // Ignored by the analyzer
        divider_t   divider;
    } divider_view_t;

    // Trigger pattern load view
    typedef struct packed {
        logic [31-`SAMPLE_WIDTH:0] unused;
        pattern_t                  pattern;
    } pattern_view_t;

    // Long command argument, read either way
    typedef union packed {
        divider_view_t div;
        pattern_view_t pat;
    } command_word_u;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,
        CMD_RECEIVED,
        META_WAIT
    } controller_state_e;

    // Which byte table the meta sender walks
    typedef enum logic {
        REPLY_ID   = 1'b0,
        REPLY_META = 1'b1
    } reply_sel_e;

endpackage

`default_nettype wire

//--- src/sump_macros.svh
`ifndef SUMP_MACROS_SVH
`define SUMP_MACROS_SVH

////////////////////////////////////////
// UART timing
////////////////////////////////////////

// Kept short so simulation stays quick
`define CLKS_PER_BIT 8

////////////////////////////////////////
// Probe geometry
////////////////////////////////////////

`define SAMPLE_WIDTH 8             // Probe channel count

////////////////////////////////////////
// SUMP opcodes
////////////////////////////////////////

// Short commands, one byte each
`define OP_RESET       8'h00
`define OP_ARM         8'h01
`define OP_QUERY_ID    8'h02
`define OP_QUERY_META  8'h04

// Long commands, bit 7 set, four argument bytes follow
`define OP_SET_DIVIDER 8'h80
`define OP_SET_RISE    8'hC0
`define OP_SET_FALL    8'hC1

`endif
